//--- filelist.f
+incdir+src
src/flight_pkg.sv
src/flight_if.sv
src/us_tick.sv
src/rc_receiver.sv
src/attitude_controller.sv
src/motor_mixer.sv
src/esc_pwm.sv
src/flight_ctrl_top.sv
sim/flight_ctrl_tb.sv

//--- Bender.yml
package:
  name: flight_ctrl

export_include_dirs:
  - src

sources:
  - src/flight_pkg.sv
  - src/flight_if.sv
  - src/us_tick.sv
  - src/rc_receiver.sv
  - src/attitude_controller.sv
  - src/motor_mixer.sv
  - src/esc_pwm.sv
  - src/flight_ctrl_top.sv
  - target: simulation
    files:
      - sim/flight_ctrl_tb.sv

//--- sim/flight_ctrl_tb.sv
/* Flight control directed testbench */

`default_nettype none
`include "flight_defs.svh"

module flight_ctrl_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import flight_pkg::*;

	localparam int cycles_per_us = `CLK_PER_US;
	localparam int frame_cycles = `ESC_FRAME_US * `CLK_PER_US;
	// Longest stick pulse and settling plus three ESC frames
	localparam int sample_us = 2300 + 100 + 3 * `ESC_FRAME_US;
	// Ten stick samples across the directed tests
	localparam int sample_count = 10;
	// 100 ns clock period
	localparam longint watchdog_ns =
		longint'(sample_count * sample_us + 10000) * `CLK_PER_US * 100;

	logic sys_clk;
	logic resetn;
	// Throttle, roll, pitch, yaw
	logic [3:0] rc_pwm;
	logic imu_valid;
	angle_t imu_roll;
	angle_t imu_pitch;
	wire motor_1_pwm;
	wire motor_2_pwm;
	wire motor_3_pwm;
	wire motor_4_pwm;
	wire [3:0] motor_pwm;

	int errors;
	int checks;
	longint cycle_count = 0;
	longint last_rise_cycle;
	int measured_us [4];
	int expected_us [4];
	logic [31:0] rng_state;

	assign motor_pwm = {motor_4_pwm, motor_3_pwm, motor_2_pwm, motor_1_pwm};

	flight_ctrl_top flight_ctrl_top_inst (
		.sys_clk(sys_clk),
		.resetn(resetn),
		.throttle_pwm(rc_pwm[0]),
		.roll_pwm(rc_pwm[1]),
		.pitch_pwm(rc_pwm[2]),
		.yaw_pwm(rc_pwm[3]),
		.imu_valid(imu_valid),
		.imu_roll(imu_roll),
		.imu_pitch(imu_pitch),
		.motor_1_pwm(motor_1_pwm),
		.motor_2_pwm(motor_2_pwm),
		.motor_3_pwm(motor_3_pwm),
		.motor_4_pwm(motor_4_pwm)
	);

	always #50 sys_clk = ~sys_clk;

	always @(posedge sys_clk) begin
		cycle_count <= cycle_count + 1;
	end

	function automatic logic [31:0] next_random_word(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Reference receiver scaling
	function automatic int stick_from_width(input int width_us);
		int clipped;
		clipped = width_us;
		if (clipped < `RC_MIN_US)
			clipped = `RC_MIN_US;
		else if (clipped > `RC_MAX_US)
			clipped = `RC_MAX_US;
		return (clipped - `RC_MIN_US) >> `RC_SCALE_SHIFT;
	endfunction

	function automatic int clamp_motor_value(input int sum);
		if (sum < 0)
			return 0;
		else if (sum > `MOTOR_MAX)
			return `MOTOR_MAX;
		return sum;
	endfunction

	// ESC pulse for a motor value
	function automatic int pulse_from_motor(input int value);
		return `RC_MIN_US + 4 * value;
	endfunction

	// Width check with one us of slack
	task automatic check_value(input string test_name, input string item,
			input int expected, input int actual);
		checks++;
		if (actual - expected > 1 || expected - actual > 1) begin
			errors++;
			$display("MISMATCH %s %s expected %0d actual %0d",
				test_name, item, expected, actual);
		end
	endtask

	// All channels rise together and each falls after its own width
	task automatic send_stick_pulses(input int w_thr, input int w_roll,
			input int w_pitch, input int w_yaw);
		int high_cycles [4];
		int longest;
		high_cycles[0] = w_thr * cycles_per_us;
		high_cycles[1] = w_roll * cycles_per_us;
		high_cycles[2] = w_pitch * cycles_per_us;
		high_cycles[3] = w_yaw * cycles_per_us;
		longest = 0;
		for (int i = 0; i < 4; i++) begin
			if (high_cycles[i] > longest)
				longest = high_cycles[i];
		end
		@(negedge sys_clk);
		rc_pwm = 4'b1111;
		for (int c = 1; c <= longest; c++) begin
			@(negedge sys_clk);
			for (int i = 0; i < 4; i++) begin
				if (c == high_cycles[i])
					rc_pwm[i] = 1'b0;
			end
		end
	endtask

	task automatic strobe_imu(input int roll_angle, input int pitch_angle);
		@(negedge sys_clk);
		imu_valid = 1'b1;
		imu_roll = angle_t'(roll_angle);
		imu_pitch = angle_t'(pitch_angle);
		@(negedge sys_clk);
		imu_valid = 1'b0;
	endtask

	// Next rising edge on motor_1_pwm within two frames
	task automatic find_frame_start(output bit found);
		logic prev;
		found = 1'b0;
		prev = motor_1_pwm;
		for (int c = 0; c < 2 * frame_cycles && !found; c++) begin
			@(negedge sys_clk);
			if (!prev && motor_1_pwm) begin
				found = 1'b1;
				last_rise_cycle = cycle_count;
			end
			prev = motor_1_pwm;
		end
		if (!found) begin
			errors++;
			$display("No pulse started on motor_1_pwm within two ESC frames");
		end
	endtask

	// Skip the frame in progress and time all four pulses of the next one
	task automatic measure_motor_pulses(output bit ok);
		int high_cycles [4];
		bit any_high;
		find_frame_start(ok);
		if (ok)
			find_frame_start(ok);
		if (ok) begin
			for (int i = 0; i < 4; i++)
				high_cycles[i] = 0;
			any_high = 1'b1;
			for (int c = 0; c < frame_cycles && any_high; c++) begin
				any_high = 1'b0;
				for (int i = 0; i < 4; i++) begin
					if (motor_pwm[i]) begin
						high_cycles[i]++;
						any_high = 1'b1;
					end
				end
				if (any_high)
					@(negedge sys_clk);
			end
			for (int i = 0; i < 4; i++)
				measured_us[i] = (high_cycles[i] + cycles_per_us / 2) / cycles_per_us;
		end
	endtask

	// One stick capture and IMU sample checked against the reference model
	task automatic run_sample(input string test_name, input int w_thr, input int w_roll,
			input int w_pitch, input int w_yaw, input int roll_angle, input int pitch_angle);
		int thr;
		int roll_rate;
		int pitch_rate;
		int yaw_rate;
		int sums [4];
		bit ok;
		thr = stick_from_width(w_thr);
		roll_rate = (stick_from_width(w_roll) - `STICK_CENTER - roll_angle)
			>>> `ANGLE_GAIN_SHIFT;
		pitch_rate = (stick_from_width(w_pitch) - `STICK_CENTER - pitch_angle)
			>>> `ANGLE_GAIN_SHIFT;
		yaw_rate = stick_from_width(w_yaw) - `STICK_CENTER;
		// X-frame signs
		sums[0] = thr + pitch_rate + roll_rate - yaw_rate;
		sums[1] = thr + pitch_rate - roll_rate + yaw_rate;
		sums[2] = thr - pitch_rate - roll_rate - yaw_rate;
		sums[3] = thr - pitch_rate + roll_rate + yaw_rate;
		for (int i = 0; i < 4; i++)
			expected_us[i] = pulse_from_motor(clamp_motor_value(sums[i]));
		send_stick_pulses(w_thr, w_roll, w_pitch, w_yaw);
		// Capture settles within two ticks and valid follows a cycle later
		repeat (30 * cycles_per_us) @(negedge sys_clk);
		strobe_imu(roll_angle, pitch_angle);
		repeat (5) @(negedge sys_clk);
		measure_motor_pulses(ok);
		if (ok) begin
			for (int i = 0; i < 4; i++)
				check_value(test_name, $sformatf("motor_%0d us", i + 1),
					expected_us[i], measured_us[i]);
		end
	endtask

	task automatic reset_pulse_widths();
		longint first_rise;
		bit ok;
		measure_motor_pulses(ok);
		if (ok) begin
			for (int i = 0; i < 4; i++)
				check_value("reset_pulses", $sformatf("motor_%0d us", i + 1),
					`RC_MIN_US, measured_us[i]);
			first_rise = last_rise_cycle;
			find_frame_start(ok);
			if (ok)
				check_value("reset_pulses", "frame us", `ESC_FRAME_US,
					int'((last_rise_cycle - first_rise) / cycles_per_us));
		end
	endtask

	task automatic centered_sticks();
		run_sample("centered_sticks", 1602, 1502, 1502, 1502, 0, 0);
	endtask

	task automatic roll_pitch_offsets();
		run_sample("roll_offset", 1502, 1702, 1502, 1502, 20, 0);
		// Odd negative error exercises the arithmetic shift
		run_sample("pitch_offset", 1502, 1502, 1402, 1502, 0, 6);
	endtask

	task automatic yaw_differential();
		int base_us;
		run_sample("yaw_offset", 1502, 1502, 1502, 1582, 0, 0);
		base_us = pulse_from_motor(stick_from_width(1502));
		check_value("yaw_offset", "motor_1 + motor_2 us", 2 * base_us,
			measured_us[0] + measured_us[1]);
		check_value("yaw_offset", "motor_3 + motor_4 us", 2 * base_us,
			measured_us[2] + measured_us[3]);
		checks++;
		if (measured_us[1] <= measured_us[0] || measured_us[3] <= measured_us[2]) begin
			errors++;
			$display("Yaw offset did not raise motors 2 and 4 above motors 1 and 3");
		end
	endtask

	task automatic clip_and_saturate();
		run_sample("clip_high", 2300, 800, 2300, 800, 0, 0);
		run_sample("clip_low", 800, 2300, 800, 2300, 0, 0);
	endtask

	task automatic random_samples();
		int widths [4];
		int angles [2];
		for (int n = 0; n < 4; n++) begin
			for (int i = 0; i < 4; i++) begin
				rng_state = next_random_word(rng_state);
				widths[i] = 950 + int'(rng_state % 1100);
				// Capture may read one us short so stay mid-step
				widths[i] = widths[i] - (widths[i] % 4) + 2;
			end
			for (int i = 0; i < 2; i++) begin
				rng_state = next_random_word(rng_state);
				angles[i] = int'(rng_state % 201) - 100;
			end
			run_sample($sformatf("random_%0d", n), widths[0], widths[1], widths[2], widths[3],
				angles[0], angles[1]);
		end
	endtask

	initial begin
		sys_clk = 1'b0;
		resetn = 1'b0;
		rc_pwm = '0;
		imu_valid = 1'b0;
		imu_roll = '0;
		imu_pitch = '0;
		errors = 0;
		checks = 0;
		last_rise_cycle = 0;
		rng_state = 32'h37d2_1ad9;
		repeat (8) @(negedge sys_clk);
		resetn = 1'b1;
		reset_pulse_widths();
		centered_sticks();
		roll_pitch_offsets();
		yaw_differential();
		clip_and_saturate();
		random_samples();
		$display("Errors: %0d of %0d checks", errors, checks);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

	// Watchdog
	initial begin
		#(watchdog_ns);
		$display("Timeout after %0d ns, the tests did not complete", watchdog_ns);
		$display("Errors: %0d of %0d checks", errors, checks);
		$display("Checks failed");
		$finish;
	end
endmodule

`default_nettype wire

//--- src/flight_ctrl_top.sv
/* Flight control top level */

`default_nettype none

module flight_ctrl_top (
	input wire sys_clk,
	input wire resetn,
	// RC receiver pulses, asynchronous
	input wire throttle_pwm,
	input wire roll_pwm,
	input wire pitch_pwm,
	input wire yaw_pwm,
	// IMU sample with strobe
	input wire imu_valid,
	input wire flight_pkg::angle_t imu_roll,
	input wire flight_pkg::angle_t imu_pitch,
	// ESC drive
	output wire motor_1_pwm,
	output wire motor_2_pwm,
	output wire motor_3_pwm,
	output wire motor_4_pwm
);
	import flight_pkg::*;

	logic tick;
	motor_t motor_1;
	motor_t motor_2;
	motor_t motor_3;
	motor_t motor_4;

	stick_if sticks_bus ();
	rate_if rates_bus ();

	us_tick us_tick_inst (
		.sys_clk(sys_clk),
		.resetn(resetn),
		.tick(tick)
	);

	rc_receiver rc_receiver_inst (
		.sys_clk(sys_clk),
		.resetn(resetn),
		.tick(tick),
		.throttle_pwm(throttle_pwm),
		.roll_pwm(roll_pwm),
		.pitch_pwm(pitch_pwm),
		.yaw_pwm(yaw_pwm),
		.sticks(sticks_bus.src)
	);

	attitude_controller attitude_controller_inst (
		.sys_clk(sys_clk),
		.resetn(resetn),
		.imu_valid(imu_valid),
		.imu_roll(imu_roll),
		.imu_pitch(imu_pitch),
		.sticks(sticks_bus.dst),
		.rates(rates_bus.src)
	);

	motor_mixer motor_mixer_inst (
		.sys_clk(sys_clk),
		.resetn(resetn),
		.rates(rates_bus.dst),
		.motor_1(motor_1),
		.motor_2(motor_2),
		.motor_3(motor_3),
		.motor_4(motor_4)
	);

	esc_pwm esc_pwm_inst (
		.sys_clk(sys_clk),
		.resetn(resetn),
		.tick(tick),
		.motor_1(motor_1),
		.motor_2(motor_2),
		.motor_3(motor_3),
		.motor_4(motor_4),
		.motor_1_pwm(motor_1_pwm),
		.motor_2_pwm(motor_2_pwm),
		.motor_3_pwm(motor_3_pwm),
		.motor_4_pwm(motor_4_pwm)
	);
endmodule

`default_nettype wire

//--- src/esc_pwm.sv
/* ESC pulse generator */

`default_nettype none
`include "flight_defs.svh"

module esc_pwm (
	input wire sys_clk,
	input wire resetn,
	input wire tick,
	input wire flight_pkg::motor_t motor_1,
	input wire flight_pkg::motor_t motor_2,
	input wire flight_pkg::motor_t motor_3,
	input wire flight_pkg::motor_t motor_4,
	output logic motor_1_pwm,
	output logic motor_2_pwm,
	output logic motor_3_pwm,
	output logic motor_4_pwm
);
	import flight_pkg::*;

	localparam logic [11:0] frame_last = 12'(`ESC_FRAME_US - 1);
	// ESC pulse starts at the same 1000 us base as the RC range
	localparam logic [11:0] pulse_base = 12'(`RC_MIN_US);

	motor_t motor_in [4];
	// Position in the frame in us
	logic [11:0] frame_cnt;
	logic running;
	logic frame_start;
	// Pulse widths for the current frame
	logic [11:0] width_q [4];
	logic [3:0] pwm_q;

	assign motor_in[0] = motor_1;
	assign motor_in[1] = motor_2;
	assign motor_in[2] = motor_3;
	assign motor_in[3] = motor_4;

	// First tick after reset opens frame zero
	assign frame_start = tick && (!running || (frame_cnt == frame_last));

	always_ff @(posedge sys_clk) begin
		if (!resetn) begin
			running <= 1'b0;
			frame_cnt <= '0;
			pwm_q <= '0;
		end else begin
			if (tick) begin
				running <= 1'b1;
				frame_cnt <= frame_start ? '0 : frame_cnt + 1'b1;
			end
			for (int i = 0; i < 4; i++)
				pwm_q[i] <= running && (frame_cnt < width_q[i]);
		end
	end

	// 1000 + 4 x value us
	always_ff @(posedge sys_clk) begin
		if (frame_start) begin
			for (int i = 0; i < 4; i++)
				width_q[i] <= pulse_base + {2'b0, motor_in[i], 2'b0};
		end
	end

	assign motor_1_pwm = pwm_q[0];
	assign motor_2_pwm = pwm_q[1];
	assign motor_3_pwm = pwm_q[2];
	assign motor_4_pwm = pwm_q[3];
endmodule

`default_nettype wire

//--- src/motor_mixer.sv
/* X-frame motor mixer */

`default_nettype none
`include "flight_defs.svh"

module motor_mixer (
	input wire sys_clk,
	input wire resetn,
	rate_if.dst rates,
	output flight_pkg::motor_t motor_1,
	output flight_pkg::motor_t motor_2,
	output flight_pkg::motor_t motor_3,
	output flight_pkg::motor_t motor_4
);
	import flight_pkg::*;

	localparam logic signed [12:0] motor_ceil = 13'(`MOTOR_MAX);

	// Operands widened to avoid overflow
	logic signed [12:0] thr;
	logic signed [12:0] roll;
	logic signed [12:0] pitch;
	logic signed [12:0] yaw;
	logic signed [12:0] sum_1;
	logic signed [12:0] sum_2;
	logic signed [12:0] sum_3;
	logic signed [12:0] sum_4;

	// Saturate to 0..MOTOR_MAX
	function automatic motor_t clamp_motor(input logic signed [12:0] s);
		if (s < 0)
			return '0;
		else if (s > motor_ceil)
			return motor_ceil[7:0];
		else
			return s[7:0];
	endfunction

	assign thr = $signed({5'b0, rates.throttle});
	assign roll = $signed({{3{rates.roll[9]}}, rates.roll});
	assign pitch = $signed({{3{rates.pitch[9]}}, rates.pitch});
	assign yaw = $signed({{3{rates.yaw[9]}}, rates.yaw});

	// Front pair on pitch, diagonals share yaw sign
	assign sum_1 = thr + pitch + roll - yaw;
	assign sum_2 = thr + pitch - roll + yaw;
	assign sum_3 = thr - pitch - roll - yaw;
	assign sum_4 = thr - pitch + roll + yaw;

	always_ff @(posedge sys_clk) begin
		if (!resetn) begin
			motor_1 <= '0;
			motor_2 <= '0;
			motor_3 <= '0;
			motor_4 <= '0;
		end else if (rates.valid) begin
			motor_1 <= clamp_motor(sum_1);
			motor_2 <= clamp_motor(sum_2);
			motor_3 <= clamp_motor(sum_3);
			motor_4 <= clamp_motor(sum_4);
		end
	end
endmodule

`default_nettype wire

//--- src/attitude_controller.sv
/* Angle error to rate targets */

`default_nettype none
`include "flight_defs.svh"

module attitude_controller (
	input wire sys_clk,
	input wire resetn,
	input wire imu_valid,
	input wire flight_pkg::angle_t imu_roll,
	input wire flight_pkg::angle_t imu_pitch,
	stick_if.dst sticks,
	rate_if.src rates
);
	import flight_pkg::*;

	// One axis per state, then a strobe cycle
	typedef enum logic [2:0] {
		st_idle,
		st_roll,
		st_pitch,
		st_yaw,
		st_done
	} state_t;

	localparam logic signed [11:0] center = 12'(`STICK_CENTER);

	state_t state;
	logic accept;
	// Sample held for the whole computation
	stick_t throttle_q;
	stick_t roll_q;
	stick_t pitch_q;
	stick_t yaw_q;
	angle_t imu_roll_q;
	angle_t imu_pitch_q;
	rate_t roll_rate;
	rate_t pitch_rate;
	rate_t yaw_rate;
	// Shared error datapath
	stick_t axis_stick;
	angle_t axis_angle;
	logic signed [11:0] stick_ofs;
	logic signed [11:0] axis_err;
	logic signed [11:0] axis_result;

	// Busy samples are dropped
	assign accept = imu_valid && sticks.valid && (state == st_idle);

	always_comb begin
		case (state)
			st_pitch: begin
				axis_stick = pitch_q;
				axis_angle = imu_pitch_q;
			end
			st_yaw: begin
				// Yaw has no angle term
				axis_stick = yaw_q;
				axis_angle = '0;
			end
			default: begin
				axis_stick = roll_q;
				axis_angle = imu_roll_q;
			end
		endcase
	end

	assign stick_ofs = $signed({4'b0, axis_stick}) - center;
	assign axis_err = stick_ofs - $signed({{2{axis_angle[9]}}, axis_angle});
	// Gain shift only on the angle axes
	assign axis_result = (state == st_yaw) ? axis_err : (axis_err >>> `ANGLE_GAIN_SHIFT);

	always_ff @(posedge sys_clk) begin
		if (!resetn) begin
			state <= st_idle;
		end else begin
			case (state)
				st_idle: state <= accept ? st_roll : st_idle;
				st_roll: state <= st_pitch;
				st_pitch: state <= st_yaw;
				st_yaw: state <= st_done;
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge sys_clk) begin
		if (accept) begin
			throttle_q <= sticks.throttle;
			roll_q <= sticks.roll;
			pitch_q <= sticks.pitch;
			yaw_q <= sticks.yaw;
			imu_roll_q <= imu_roll;
			imu_pitch_q <= imu_pitch;
		end
		if (state == st_roll)
			roll_rate <= axis_result[9:0];
		if (state == st_pitch)
			pitch_rate <= axis_result[9:0];
		if (state == st_yaw)
			yaw_rate <= axis_result[9:0];
	end

	assign rates.throttle = throttle_q;
	assign rates.roll = roll_rate;
	assign rates.pitch = pitch_rate;
	assign rates.yaw = yaw_rate;
	// Four cycles after the accepted sample
	assign rates.valid = (state == st_done);
endmodule

`default_nettype wire

//--- src/rc_receiver.sv
/* Four-channel RC pulse capture */

`default_nettype none
`include "flight_defs.svh"

module rc_receiver (
	input wire sys_clk,
	input wire resetn,
	input wire tick,
	input wire throttle_pwm,
	input wire roll_pwm,
	input wire pitch_pwm,
	input wire yaw_pwm,
	stick_if.src sticks
);
	import flight_pkg::*;

	// Channel order throttle, roll, pitch, yaw
	logic [3:0] pwm_in;
	// Two-flop synchronizer and edge history
	logic [3:0] sync_1;
	logic [3:0] sync_2;
	logic [3:0] pwm_prev;
	logic [3:0] rise;
	logic [3:0] fall;
	// High time in us, saturating
	logic [11:0] width_cnt [4];
	stick_t stick_val [4];
	// Each channel has finished one capture
	logic [3:0] seen;
	logic valid_q;

	// Clip to the legal range then scale to 0..250
	function automatic stick_t scale_width(input logic [11:0] width);
		logic [11:0] clipped;
		logic [11:0] ofs;
		logic [11:0] scaled;
		if (width < 12'(`RC_MIN_US))
			clipped = 12'(`RC_MIN_US);
		else if (width > 12'(`RC_MAX_US))
			clipped = 12'(`RC_MAX_US);
		else
			clipped = width;
		ofs = clipped - 12'(`RC_MIN_US);
		scaled = ofs >> `RC_SCALE_SHIFT;
		return scaled[7:0];
	endfunction

	assign pwm_in = {yaw_pwm, pitch_pwm, roll_pwm, throttle_pwm};
	assign rise = sync_2 & ~pwm_prev;
	assign fall = ~sync_2 & pwm_prev;

	always_ff @(posedge sys_clk) begin
		if (!resetn) begin
			sync_1 <= '0;
			sync_2 <= '0;
			pwm_prev <= '0;
			seen <= '0;
			valid_q <= 1'b0;
		end else begin
			sync_1 <= pwm_in;
			sync_2 <= sync_1;
			pwm_prev <= sync_2;
			seen <= seen | fall;
			// Stays high until reset
			valid_q <= valid_q | (&seen);
		end
	end

	// Width counters and captured values
	always_ff @(posedge sys_clk) begin
		for (int i = 0; i < 4; i++) begin
			if (rise[i])
				width_cnt[i] <= '0;
			else if (sync_2[i] && tick && (width_cnt[i] != '1))
				width_cnt[i] <= width_cnt[i] + 1'b1;
			if (fall[i])
				stick_val[i] <= scale_width(width_cnt[i]);
		end
	end

	assign sticks.throttle = stick_val[0];
	assign sticks.roll = stick_val[1];
	assign sticks.pitch = stick_val[2];
	assign sticks.yaw = stick_val[3];
	assign sticks.valid = valid_q;
endmodule

`default_nettype wire

//--- src/us_tick.sv
/* Microsecond tick divider */

`default_nettype none
`include "flight_defs.svh"

module us_tick (
	input wire sys_clk,
	input wire resetn,
	output logic tick
);
	localparam int cnt_w = $clog2(`CLK_PER_US);
	localparam logic [cnt_w-1:0] cnt_last = cnt_w'(`CLK_PER_US - 1);

	// Cycle position inside the current microsecond
	logic [cnt_w-1:0] cnt;

	always_ff @(posedge sys_clk) begin
		if (!resetn) begin
			cnt <= '0;
			tick <= 1'b0;
		end else begin
			// Pulse on wrap, one cycle wide
			tick <= (cnt == cnt_last);
			cnt <= (cnt == cnt_last) ? '0 : cnt + 1'b1;
		end
	end
endmodule

`default_nettype wire

//--- src/flight_if.sv
/* Stick and rate buses */

`default_nettype none

// Receiver to controller
interface stick_if;
	import flight_pkg::*;

	// Latest captured stick positions
	stick_t throttle;
	stick_t roll;
	stick_t pitch;
	stick_t yaw;
	// Level, high once all channels captured
	logic valid;

	modport src (output throttle, roll, pitch, yaw, valid);
	modport dst (input throttle, roll, pitch, yaw, valid);
endinterface

// Controller to mixer
interface rate_if;
	import flight_pkg::*;

	// Throttle passes through untouched
	stick_t throttle;
	// Signed rate targets
	rate_t roll;
	rate_t pitch;
	rate_t yaw;
	// One-cycle strobe for a fresh set
	logic valid;

	modport src (output throttle, roll, pitch, yaw, valid);
	modport dst (input throttle, roll, pitch, yaw, valid);
endinterface

`default_nettype wire

//--- src/flight_pkg.sv
/* Flight control value types */

`default_nettype none

package flight_pkg;

	// Stick position from the receiver
	// Range 0..250, centre at 125
	typedef logic [7:0] stick_t;

	// Signed axis rate from the controller
	// Two's complement, roughly -320..320 in use
	typedef logic signed [9:0] rate_t;

	// IMU angle already in stick units
	// Zero means level on that axis
	typedef logic signed [9:0] angle_t;

	// Motor command after the mixer
	// Range 0..250, maps to 1000..2000 us at the ESC
	typedef logic [7:0] motor_t;

endpackage

`default_nettype wire

//--- src/flight_defs.svh
/* Flight control timing and scaling constants */

`ifndef FLIGHT_DEFS_SVH
`define FLIGHT_DEFS_SVH

// sys_clk cycles in one microsecond
`define CLK_PER_US 10

// Valid RC stick pulse range in us
`define RC_MIN_US 1000
`define RC_MAX_US 2000
// us above minimum to stick units
`define RC_SCALE_SHIFT 2

// Neutral stick position
`define STICK_CENTER 125
// Halves the angle error
`define ANGLE_GAIN_SHIFT 1

// Motor ceiling, also top of stick range
`define MOTOR_MAX 250
// ESC refresh period in us
`define ESC_FRAME_US 2500

`endif
